// File: compile.f
verilog/stats_pkg.sv
verilog/sample_frame_buffer.sv
verilog/variance_unit.sv
verilog/integer_sqrt.sv
verilog/frame_stats_top.sv
testbench/frame_stats_props.sv
testbench/frame_stats_tb.sv

// File: testbench/frame_stats_tb.sv
`timescale 1ns/1ps

module frame_stats_tb;

	localparam int NUM_FRAMES = 12;
	localparam int RESULT_LATENCY = 28;                  // 16th sample edge to result
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * 60 + 100;
	localparam int N = stats_pkg::TOTAL_SAMPLES;

	logic                              clk;
	logic                              rst_n;
	logic [stats_pkg::DATA_WIDTH-1:0]  sample_in;
	logic                              sample_valid;
	logic                              busy;
	logic [stats_pkg::DATA_WIDTH-1:0]  mean_out;
	logic [stats_pkg::VAR_WIDTH-1:0]   variance_out;
	logic [stats_pkg::ROOT_WIDTH-1:0]  stddev_out;
	logic                              result_valid;

	int cyc = 0;         // Rising edges so far
	int errors = 0;
	int checks = 0;
	int results = 0;
	int exp_mean_q[$];
	int exp_var_q[$];
	int exp_sd_q[$];
	int exp_edge_q[$];   // Edge that took each frame's 16th sample
	int frame_vals[N];

	frame_stats_top UUT (.clk, .rst_n, .sample_in, .sample_valid, .busy,
		.mean_out, .variance_out, .stddev_out, .result_valid);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	// Watchdog
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("Run timed out after %0d cycles with %0d of %0d results seen",
				cyc, results, NUM_FRAMES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Largest r with r*r <= v
	function automatic int floor_sqrt(int v);
		int r;
		r = 0;
		while ((r + 1) * (r + 1) <= v)
			r++;
		return r;
	endfunction

	task automatic push_expected(int done_cyc);
		int sum;
		int mean;
		int sq_sum;
		sum = 0;
		sq_sum = 0;
		foreach (frame_vals[i])
			sum += frame_vals[i];
		mean = sum / N;                                 // Floor, sum is non-negative
		foreach (frame_vals[i])
			sq_sum += (frame_vals[i] - mean) * (frame_vals[i] - mean);
		exp_mean_q.push_back(mean);
		exp_var_q.push_back(sq_sum / N);
		exp_sd_q.push_back(floor_sqrt(sq_sum / N));
		exp_edge_q.push_back(done_cyc);
	endtask

	task automatic strobe(int v);
		@(posedge clk);
		#1;
		sample_in = v[stats_pkg::DATA_WIDTH-1:0];
		sample_valid = 1'b1;
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			sample_valid = 1'b0;
		end
	endtask

	// Valid low until replay is over
	task automatic wait_idle();
		do begin
			@(posedge clk);
			#1;
			sample_valid = 1'b0;
		end while (busy);
	endtask

	task automatic send_frame(int kind, bit inject);
		int done_cyc;
		for (int i = 0; i < N; i++) begin
			case (kind)
				1: frame_vals[i] = 255;                   // Largest possible sum
				2: frame_vals[i] = 37;                    // Flat frame, zero spread
				3: frame_vals[i] = (i % 2) ? 255 : 0;
				default: frame_vals[i] = $urandom_range(255, 0);
			endcase
			strobe(frame_vals[i]);
			if (i < N - 1)
				idle($urandom_range(2, 0));
		end
		done_cyc = cyc + 1;  // Taken on the coming edge
		push_expected(done_cyc);
		if (inject) begin
			// Lands inside the replay window, must not count
			repeat (3) begin
				idle(1);
				strobe($urandom_range(255, 0));
			end
		end
		wait_idle();
	endtask

	// One output against its reset value
	task automatic check_zero(string name, logic [31:0] got);
		checks++;
		assert (got == 0) else begin
			$display("FAIL %0t %s got %0d expected 0", $time, name, got);
			errors++;
		end
	endtask

	task automatic check_reset_outputs();
		check_zero("busy", busy);
		check_zero("result_valid", result_valid);
		check_zero("mean_out", mean_out);
		check_zero("variance_out", variance_out);
		check_zero("stddev_out", stddev_out);
	endtask

	task automatic check_result();
		int exp_mean;
		int exp_var;
		int exp_sd;
		int exp_edge;
		if (exp_mean_q.size() == 0) begin
			$display("Result strobe at %0t with no frame outstanding", $time);
			errors++;
			return;
		end
		exp_mean = exp_mean_q.pop_front();
		exp_var = exp_var_q.pop_front();
		exp_sd = exp_sd_q.pop_front();
		exp_edge = exp_edge_q.pop_front();
		results++;
		checks += 4;
		assert (mean_out == exp_mean) else begin
			$display("FAIL %0t mean_out got %0d expected %0d", $time, mean_out, exp_mean);
			errors++;
		end
		assert (variance_out == exp_var) else begin
			$display("FAIL %0t variance_out got %0d expected %0d", $time, variance_out, exp_var);
			errors++;
		end
		assert (stddev_out == exp_sd) else begin
			$display("FAIL %0t stddev_out got %0d expected %0d", $time, stddev_out, exp_sd);
			errors++;
		end
		assert (cyc - exp_edge == RESULT_LATENCY) else begin
			$display("FAIL %0t result_valid latency got %0d expected %0d",
				$time, cyc - exp_edge, RESULT_LATENCY);
			errors++;
		end
	endtask

	// Outputs settled half a cycle after the edge
	always @(negedge clk) begin
		if (rst_n && result_valid)
			check_result();
	end

	initial begin
		int kind;
		bit inject;
		void'($urandom(81));
		rst_n = 1'b0;
		sample_in = '0;
		sample_valid = 1'b0;
		repeat (4) begin
			@(posedge clk);
			#1;
			check_reset_outputs();
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_reset_outputs();  // Just after release
		for (int f = 0; f < NUM_FRAMES; f++) begin
			kind = (f == 1) ? 1 : (f == 3) ? 2 : (f == 4) ? 3 : 0;
			inject = (f == 2) || (f == 6);
			send_frame(kind, inject);
		end
		while (results < NUM_FRAMES)
			@(posedge clk);
		idle(4);
		$display("Checks %0d, value errors %0d, property errors %0d",
			checks, errors, UUT.u_props.prop_errors);
		if (errors == 0 && UUT.u_props.prop_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: testbench/frame_stats_props.sv
`timescale 1ns/1ps

module frame_stats_props (
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic variance_valid,
	input logic result_valid
);

	int prop_errors = 0;  // Read by the testbench for its closing line

	// Result strobe is a single cycle
	property result_one_cycle;
		@(posedge clk) disable iff (!rst_n)
			result_valid |=> !result_valid;
	endproperty

	// Replay window is exactly one frame long
	property busy_sixteen_cycles;
		@(posedge clk) disable iff (!rst_n)
			$rose(busy) |-> busy [*16] ##1 !busy;
	endproperty

	// Load cycle plus 8 root iterations
	property root_after_variance;
		@(posedge clk) disable iff (!rst_n)
			variance_valid |-> ##9 result_valid;
	endproperty

	assert property (result_one_cycle)
		else begin prop_errors++; $error("result_valid held longer than one cycle"); end
	assert property (busy_sixteen_cycles)
		else begin prop_errors++; $error("busy not high for exactly 16 cycles"); end
	assert property (root_after_variance)
		else begin prop_errors++; $error("result_valid not 9 cycles after variance_valid"); end

endmodule

bind frame_stats_top frame_stats_props u_props (.clk(clk), .rst_n(rst_n), .busy(busy),
	.variance_valid(variance_valid), .result_valid(result_valid));

// File: verilog/frame_stats_top.sv
`timescale 1ns/1ps

module frame_stats_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [stats_pkg::DATA_WIDTH-1:0]    sample_in,
	input  logic                                sample_valid,
	output logic                                busy,
	output logic [stats_pkg::DATA_WIDTH-1:0]    mean_out,
	output logic [stats_pkg::VAR_WIDTH-1:0]     variance_out,
	output logic [stats_pkg::ROOT_WIDTH-1:0]    stddev_out,
	output logic                                result_valid
);

	logic                              replay_start;
	logic [stats_pkg::DATA_WIDTH-1:0]  replay_data;
	logic                              replay_valid;
	logic [stats_pkg::DATA_WIDTH-1:0]  mean_value;
	logic [stats_pkg::VAR_WIDTH-1:0]   variance_value;
	logic                              variance_valid;
	logic [stats_pkg::ROOT_WIDTH-1:0]  root_value;
	logic                              root_valid;

	// Per-frame captures, then the values shown between results
	logic [stats_pkg::DATA_WIDTH-1:0]  mean_hold;
	logic [stats_pkg::VAR_WIDTH-1:0]   var_hold;
	logic [stats_pkg::DATA_WIDTH-1:0]  mean_res;
	logic [stats_pkg::VAR_WIDTH-1:0]   var_res;

	sample_frame_buffer u_buffer (.clk, .rst_n, .sample_in, .sample_valid, .busy,
		.replay_start, .replay_data, .replay_valid, .mean_value);

	variance_unit u_variance (.clk, .rst_n, .replay_data, .replay_valid, .replay_start,
		.mean_value, .variance_value, .variance_valid);

	integer_sqrt u_sqrt (.clk, .rst_n, .variance_value, .variance_valid,
		.root_value, .root_valid);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mean_hold <= '0;
			var_hold  <= '0;
			mean_res  <= '0;
			var_res   <= '0;
		end else begin
			if (replay_start)
				mean_hold <= mean_value;        // Buffer reuses it next frame
			if (variance_valid)
				var_hold <= variance_value;
			if (root_valid) begin
				mean_res <= mean_hold;          // Shown until the next result
				var_res  <= var_hold;
			end
		end
	end

	// Fresh values during the strobe cycle itself
	assign mean_out     = root_valid ? mean_hold : mean_res;
	assign variance_out = root_valid ? var_hold : var_res;
	assign stddev_out   = root_value;
	assign result_valid = root_valid;

endmodule

// File: verilog/integer_sqrt.sv
`timescale 1ns/1ps

module integer_sqrt (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [stats_pkg::VAR_WIDTH-1:0]     variance_value,  // Radicand
	input  logic                                variance_valid,  // Load, restarts any run
	output logic [stats_pkg::ROOT_WIDTH-1:0]    root_value,      // Held until next result
	output logic                                root_valid
);

	logic [stats_pkg::VAR_WIDTH-1:0]   rad_q;      // Radicand, top pair consumed each step
	logic [stats_pkg::ROOT_WIDTH-1:0]  rem_q;      // Partial remainder
	logic [stats_pkg::ROOT_WIDTH-1:0]  q_q;        // Root bits found so far
	logic [stats_pkg::ROOT_WIDTH-1:0]  bit_sel;    // One-hot, result bit being tried
	logic [stats_pkg::ROOT_WIDTH+1:0]  rem_shift;
	logic [stats_pkg::ROOT_WIDTH+1:0]  trial;
	logic [stats_pkg::ROOT_WIDTH+1:0]  rem_next;
	logic [stats_pkg::ROOT_WIDTH-1:0]  q_next;
	logic                              active;
	logic                              fits;

	assign active = |bit_sel;

	// Bring down the next two radicand bits
	assign rem_shift = {rem_q, rad_q[stats_pkg::VAR_WIDTH-1 -: 2]};
	assign trial = {q_q, 2'b01};        // 4q + 1
	assign fits = (rem_shift >= trial);
	assign rem_next = fits ? (rem_shift - trial) : rem_shift;  // Restore on miss
	assign q_next = {q_q[stats_pkg::ROOT_WIDTH-2:0], fits};

	// Working registers
	always_ff @(posedge clk) begin
		if (variance_valid) begin
			rad_q <= variance_value;
			rem_q <= '0;
			q_q   <= '0;
		end else if (active) begin
			rad_q <= rad_q << 2;
			// Below 2^ROOT_WIDTH until the last step, which is not reused
			rem_q <= rem_next[stats_pkg::ROOT_WIDTH-1:0];
			q_q   <= q_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_sel    <= '0;
			root_value <= '0;
			root_valid <= 1'b0;
		end else begin
			root_valid <= 1'b0;
			if (variance_valid) begin
				bit_sel <= {1'b1, {(stats_pkg::ROOT_WIDTH - 1){1'b0}}};  // Start at MSB
			end else if (active) begin
				bit_sel <= bit_sel >> 1;
				if (bit_sel[0]) begin
					// LSB decided, publish
					root_value <= q_next;
					root_valid <= 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/variance_unit.sv
`timescale 1ns/1ps

module variance_unit (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [stats_pkg::DATA_WIDTH-1:0]    replay_data,
	input  logic                                replay_valid,
	input  logic                                replay_start,   // Clears the accumulator
	input  logic [stats_pkg::DATA_WIDTH-1:0]    mean_value,
	output logic [stats_pkg::VAR_WIDTH-1:0]     variance_value, // Held between frames
	output logic                                variance_valid
);

	logic signed [stats_pkg::DIFF_WIDTH-1:0]     diff_q;
	logic signed [2*stats_pkg::DIFF_WIDTH-1:0]   product;
	logic [stats_pkg::SQUARE_WIDTH-1:0]          square_q;
	logic                                        diff_valid;    // Tags diff_q
	logic                                        square_valid;  // Tags square_q
	logic [stats_pkg::VAR_SUM_WIDTH-1:0]         var_acc;
	logic [stats_pkg::COUNT_WIDTH-1:0]           sq_cnt;        // Squares summed so far

	// Square of a 9-bit signed value, always non-negative
	assign product = diff_q * diff_q;

	// Stage 1 and 2 datapath
	always_ff @(posedge clk) begin
		if (replay_valid)
			diff_q <= $signed({1'b0, replay_data}) - $signed({1'b0, mean_value});
		if (diff_valid)
			square_q <= product[stats_pkg::SQUARE_WIDTH-1:0];  // Upper bits are zero
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			diff_valid     <= 1'b0;
			square_valid   <= 1'b0;
			var_acc        <= '0;
			sq_cnt         <= '0;
			variance_value <= '0;
			variance_valid <= 1'b0;
		end else begin
			// Valid travels beside the data
			diff_valid     <= replay_valid;
			square_valid   <= diff_valid;
			variance_valid <= 1'b0;

			// Stage 3, accumulate and close
			if (replay_start) begin
				var_acc <= '0;
				sq_cnt  <= '0;
			end else if (square_valid) begin
				var_acc <= var_acc +
					{{(stats_pkg::VAR_SUM_WIDTH - stats_pkg::SQUARE_WIDTH){1'b0}}, square_q};
				sq_cnt  <= sq_cnt + 1'b1;
			end else if (sq_cnt == stats_pkg::TOTAL_SAMPLES) begin
				// 16th square is in, divide by 16
				variance_value <=
					var_acc[stats_pkg::VAR_SUM_WIDTH-1:stats_pkg::LOG2_SAMPLES];
				variance_valid <= 1'b1;
				sq_cnt         <= '0;
			end
		end
	end

endmodule

// File: verilog/sample_frame_buffer.sv
`timescale 1ns/1ps

module sample_frame_buffer (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [stats_pkg::DATA_WIDTH-1:0]    sample_in,
	input  logic                                sample_valid,  // One strobe per sample
	output logic                                busy,          // High during replay
	output logic                                replay_start,  // Pulse with first replay word
	output logic [stats_pkg::DATA_WIDTH-1:0]    replay_data,
	output logic                                replay_valid,
	output logic [stats_pkg::DATA_WIDTH-1:0]    mean_value     // Held until next frame ends
);

	// Frame storage, one entry per accepted sample
	logic [stats_pkg::DATA_WIDTH-1:0] frame_mem [stats_pkg::TOTAL_SAMPLES];

	logic [stats_pkg::COUNT_WIDTH-1:0] wr_cnt;   // Samples taken so far
	logic [stats_pkg::COUNT_WIDTH-1:0] rd_cnt;   // Next entry to replay
	logic [stats_pkg::SUM_WIDTH-1:0]   sum_acc;
	logic [stats_pkg::SUM_WIDTH-1:0]   sum_next;
	logic                              accept;
	logic                              frame_done;
	logic                              replay_step;

	// Samples that show up while replaying are simply lost
	assign accept = sample_valid && !busy;
	assign frame_done = accept && (wr_cnt == stats_pkg::TOTAL_SAMPLES - 1);  // 16th sample
	assign replay_step = busy && (rd_cnt != stats_pkg::TOTAL_SAMPLES);

	// Running sum including the sample on the bus this cycle
	assign sum_next = sum_acc +
		{{(stats_pkg::SUM_WIDTH - stats_pkg::DATA_WIDTH){1'b0}}, sample_in};

	always_ff @(posedge clk) begin
		if (accept)
			frame_mem[wr_cnt[stats_pkg::LOG2_SAMPLES-1:0]] <= sample_in;
	end

	// Read side of the memory
	// Entry 0 is already stored when the last sample lands, so it goes out first
	always_ff @(posedge clk) begin
		if (frame_done)
			replay_data <= frame_mem[0];
		else if (replay_step)
			replay_data <= frame_mem[rd_cnt[stats_pkg::LOG2_SAMPLES-1:0]];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_cnt       <= '0;
			rd_cnt       <= '0;
			sum_acc      <= '0;
			mean_value   <= '0;
			busy         <= 1'b0;
			replay_start <= 1'b0;
			replay_valid <= 1'b0;
		end else begin
			replay_start <= frame_done;  // Single cycle
			if (frame_done) begin
				wr_cnt       <= '0;
				sum_acc      <= '0;
				// Floor divide by 16
				mean_value   <= sum_next[stats_pkg::SUM_WIDTH-1:stats_pkg::LOG2_SAMPLES];
				busy         <= 1'b1;
				replay_valid <= 1'b1;
				rd_cnt       <= {{(stats_pkg::COUNT_WIDTH - 1){1'b0}}, 1'b1};  // Entry 0 sent
			end else if (accept) begin
				wr_cnt  <= wr_cnt + 1'b1;
				sum_acc <= sum_next;
			end else if (busy) begin
				if (rd_cnt == stats_pkg::TOTAL_SAMPLES) begin
					// All 16 words out, open for the next frame
					busy         <= 1'b0;
					replay_valid <= 1'b0;
					rd_cnt       <= '0;
				end else begin
					rd_cnt <= rd_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/stats_pkg.sv
package stats_pkg;

	// Sample format
	localparam int DATA_WIDTH = 8;      // Unsigned samples only

	// Frame length, power of two so division is a shift
	localparam int TOTAL_SAMPLES = 16;
	localparam int LOG2_SAMPLES = 4;
	localparam int COUNT_WIDTH = 5;     // Reaches TOTAL_SAMPLES itself

	// Mean path
	localparam int SUM_WIDTH = 12;      // 16 x 255 = 4080

	// Variance path
	localparam int DIFF_WIDTH = 9;      // Sign bit plus sample width
	localparam int SQUARE_WIDTH = 16;   // 255^2 = 65025
	localparam int VAR_SUM_WIDTH = 20;  // 16 x 65025 still fits
	localparam int VAR_WIDTH = 16;

	// Square root result
	localparam int ROOT_WIDTH = 8;      // Half of VAR_WIDTH

endpackage
